// File: all.f
+incdir+src
src/rec_cmd_pkg.sv
src/rec_csr_pkg.sv
src/rec_cmd_fsm.sv
src/rec_xfer_counter.sv
src/rec_csr_file.sv
src/rec_indirect_fifo.sv
src/recovery_executor.sv
dv/tb_clk_gen.sv
dv/tb_recovery_executor.sv

// File: Bender.yml
package:
  name: recovery_executor

export_include_dirs:
  - src

sources:
  - src/rec_cmd_pkg.sv
  - src/rec_csr_pkg.sv
  - src/rec_cmd_fsm.sv
  - src/rec_xfer_counter.sv
  - src/rec_csr_file.sv
  - src/rec_indirect_fifo.sv
  - src/recovery_executor.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_recovery_executor.sv

// File: dv/tb_recovery_executor.sv
// Simulation top that drives random commands into the recovery executor and checks a model
`timescale 1ns/1ps
`include "rec_cfg.svh"

module tb_recovery_executor
  import rec_cmd_pkg::*;
;

  localparam int Depth = `REC_FIFO_DEPTH;
  localparam int NumCmds = 200;

  logic clk_i, rst_ni;
  logic cmd_valid_i, cmd_is_rd_i, cmd_error_i, res_ready_i, res_dready_i;
  logic tti_rx_rack_i, fifo_rreq_i, recovery_mode_enabled_i, host_abort_i;
  rec_cmd_e cmd_cmd_i;
  logic [15:0] cmd_len_i, recovery_status_i, res_len_o;
  logic [31:0] tti_rx_rdata_i, fifo_rdata_o;
  logic cmd_done_o, res_valid_o, res_dvalid_o, res_dlast_o, tti_rx_rreq_o;
  logic rx_queue_clr_o, payload_available_o, image_activated_o;
  logic [7:0] res_data_o;
  rec_prot_err_e prot_error_o;
  logic [23:0] device_reset_o, recovery_ctrl_o;

  // Model state
  logic [23:0] dev_m, ctrl_m;
  logic [7:0] cms_m, frst_m;
  logic [31:0] isize_m;
  logic [31:0] fq[$];
  int wr_m, rd_m, errors, checks;
  logic pay_m, fclr_m;

  tb_clk_gen u_clk (.clk_o(clk_i), .rst_no(rst_ni));

  recovery_executor DUT (.*);

  task automatic report_mismatch(input string msg);
    errors++;
    $display("FAIL @%0t: %s", $time, msg);
  endtask

  function automatic int start_idx(input logic [7:0] c);
    case (c)
      8'd37: return 0;
      8'd38: return 1;
      8'd39: return 2;
      8'd45: return 3;
      default: return 5;
    endcase
  endfunction

  function automatic int byte_len(input logic [7:0] c);
    case (c)
      8'd37, 8'd38: return 3;
      8'd39: return 2;
      8'd45: return 6;
      default: return 20;
    endcase
  endfunction

  function automatic logic [31:0] model_word(input int idx);
    case (idx)
      0: return {8'h00, dev_m};
      1: return {8'h00, ctrl_m};
      2: return {16'h0000, recovery_status_i};
      3: return {16'h0000, frst_m, cms_m};
      4: return isize_m;
      5: return {30'd0, fq.size() == Depth, fq.size() == 0};
      6: return wr_m;
      7: return rd_m;
      8: return Depth;
      default: return 0;
    endcase
  endfunction

  // Advances the FIFO model and the payload flag by the next clock edge
  task automatic step_model(input logic pop, input logic push, input logic [31:0] pdata);
    logic full, empty;
    full = (fq.size() == Depth);
    empty = (fq.size() == 0);
    fifo_rreq_i = pop;
    checks++;
    if (payload_available_o !== pay_m)
      report_mismatch($sformatf("payload available %b, expected %b",
                                payload_available_o, pay_m));
    if (!pay_m && (full || ctrl_m[23:16] == `REC_ACTIVATE_CODE)) pay_m = 1'b1;
    else if (pay_m && empty) pay_m = 1'b0;
    if (fclr_m) begin
      // Clear wins over a pop in the same cycle
      fq.delete();
      wr_m = 0;
      rd_m = 0;
      fclr_m = 1'b0;
    end else begin
      if (pop && !empty) begin
        checks++;
        if (fifo_rdata_o !== fq[0]) report_mismatch($sformatf("FIFO head %h, expected %h",
                                                              fifo_rdata_o, fq[0]));
        void'(fq.pop_front());
        rd_m = (rd_m + 1) % Depth;
      end
      if (push && !full) begin
        fq.push_back(pdata);
        wr_m = (wr_m + 1) % Depth;
      end
    end
  endtask

  task automatic apply_write(input logic [7:0] c, input int k, input logic [31:0] w);
    if (k < (byte_len(c) + 3) / 4) begin
      case (start_idx(c) + k)
        0: dev_m = w[23:0];
        1: ctrl_m = w[23:0];
        3: begin
          cms_m = w[7:0];
          frst_m = (w[15:8] == `REC_FIFO_RESET_CODE) ? 8'h00 : w[15:8];
          // FIFO empties at the edge after the register write
          if (w[15:8] == `REC_FIFO_RESET_CODE) fclr_m = 1'b1;
        end
        4: isize_m = w;
        default: ;
      endcase
    end
  endtask

  task automatic idle(input int n, input logic drain);
    repeat (n) begin
      @(negedge clk_i);
      step_model(drain && ($urandom % 3 == 0), 1'b0, '0);
    end
  endtask

  task automatic run_cmd(input logic rd, input logic [7:0] c, input logic [15:0] len,
                         input logic err, input logic abort);
    int cyc, delay, widx, bidx, nbytes, abort_at, clr_cyc;
    logic pend, bad, rec_only, supported, done, aborted, pop;
    logic [31:0] w;
    logic [7:0] exp_byte;
    rec_prot_err_e exp_err;
    supported = (c inside {8'd37, 8'd38, 8'd39, 8'd45, 8'd46, 8'd47});
    rec_only = (c inside {8'd45, 8'd46, 8'd47});
    bad = err || !supported || (rec_only && !recovery_mode_enabled_i) || (rd && c == 8'd47);
    nbytes = byte_len(c);
    abort_at = $urandom % nbytes;
    cyc = 0;
    widx = 0;
    bidx = 0;
    pend = 0;
    done = 0;
    aborted = 0;
    clr_cyc = -1;
    delay = 0;
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_is_rd_i = rd;
    cmd_cmd_i = rec_cmd_e'(c);
    cmd_len_i = len;
    cmd_error_i = err;
    step_model(1'b0, 1'b0, '0);
    while (!done) begin
      @(negedge clk_i);
      cyc++;
      tti_rx_rack_i = 1'b0;
      res_ready_i = 1'b0;
      res_dready_i = 1'b0;
      host_abort_i = 1'b0;
      if (rx_queue_clr_o) clr_cyc = cyc;
      if (cmd_done_o) begin
        checks++;
        if (bad && cyc != 2) report_mismatch($sformatf("error done at cycle %0d", cyc));
        if (!bad && !rd && len == 0 && cyc != 1)
          report_mismatch($sformatf("empty write done at cycle %0d", cyc));
        if (!bad && !rd && widx != (len + 3) / 4)
          report_mismatch($sformatf("%0d words consumed, expected %0d", widx, (len + 3) / 4));
        if (!bad && rd && !aborted && bidx != nbytes)
          report_mismatch($sformatf("%0d bytes sent, expected %0d", bidx, nbytes));
        if ((bad || aborted) && clr_cyc != cyc - 1) report_mismatch("queue clear missing");
        if (!bad && !aborted && clr_cyc != -1) report_mismatch("unexpected queue clear");
        cmd_valid_i = 1'b0;
        step_model(1'b0, 1'b0, '0);
        done = 1'b1;
      end else begin
        if (tti_rx_rreq_o) begin
          if (bad || rd) report_mismatch("receive request on a read or failed command");
          pend = 1'b1;
          delay = $urandom % 4;
        end
        pop = (c == 8'd47) && !rd && ($urandom % 3 == 0);
        w = $urandom;
        if (pend && delay == 0) begin
          if (c == 8'd38 && $urandom % 2) w[23:16] = `REC_ACTIVATE_CODE;
          if (c == 8'd45 && $urandom % 2) w[15:8] = `REC_FIFO_RESET_CODE;
          tti_rx_rack_i = 1'b1;
          tti_rx_rdata_i = w;
          pend = 1'b0;
        end else if (pend) begin
          delay--;
        end
        if (res_valid_o) begin
          checks++;
          if (res_len_o !== nbytes)
            report_mismatch($sformatf("length %0d, expected %0d", res_len_o, nbytes));
          res_ready_i = $urandom % 2;
        end
        if (res_dvalid_o) begin
          checks++;
          if (res_dlast_o !== (bidx == nbytes - 1)) report_mismatch("last flag misplaced");
          if (abort && bidx == abort_at && !aborted) begin
            host_abort_i = 1'b1;
            aborted = 1'b1;
          end else if ($urandom % 4 != 0) begin
            res_dready_i = 1'b1;
            exp_byte = model_word(start_idx(c) + bidx / 4) >> (8 * (bidx % 4));
            checks++;
            if (res_data_o !== exp_byte)
              report_mismatch($sformatf("byte %0d is %h, expected %h", bidx, res_data_o,
                                        exp_byte));
            bidx++;
          end
        end
        step_model(pop, tti_rx_rack_i && c == 8'd47, w);
        if (tti_rx_rack_i && c != 8'd47) apply_write(c, widx, w);
        if (tti_rx_rack_i) widx++;
      end
    end
    // Flags settle one cycle after Done
    idle(1, 1'b0);
    exp_err = err ? PROT_CRC : ((bad || aborted) ? PROT_PARAMETER : PROT_OK);
    checks++;
    if (prot_error_o !== exp_err)
      report_mismatch($sformatf("protocol error %h, expected %h", prot_error_o, exp_err));
    if (device_reset_o !== dev_m) report_mismatch("device reset register mismatch");
    if (recovery_ctrl_o !== ctrl_m) report_mismatch("recovery control register mismatch");
    if (image_activated_o !== (ctrl_m[23:16] == `REC_ACTIVATE_CODE))
      report_mismatch("image activated flag mismatch");
  endtask

  initial begin
    automatic logic [7:0] c;
    automatic logic [7:0] legal[5] = '{8'd37, 8'd38, 8'd39, 8'd45, 8'd46};
    automatic logic rd, err;
    automatic logic [15:0] len;
    cmd_valid_i = 0;
    cmd_is_rd_i = 0;
    cmd_cmd_i = CMD_DEVICE_RESET;
    cmd_len_i = 0;
    cmd_error_i = 0;
    res_ready_i = 0;
    res_dready_i = 0;
    tti_rx_rack_i = 0;
    tti_rx_rdata_i = 0;
    fifo_rreq_i = 0;
    recovery_mode_enabled_i = 0;
    host_abort_i = 0;
    recovery_status_i = 0;
    dev_m = 0;
    ctrl_m = 0;
    cms_m = 0;
    frst_m = 0;
    isize_m = 0;
    wr_m = 0;
    rd_m = 0;
    pay_m = 0;
    fclr_m = 0;
    errors = 0;
    checks = 0;
    void'($urandom(32'h1754_f16a));
    @(posedge rst_ni);
    @(posedge clk_i);
    for (int n = 0; n < NumCmds; n++) begin
      rd = 0;
      err = 0;
      len = $urandom % 13;
      c = legal[$urandom % 5];
      recovery_mode_enabled_i = ($urandom % 5 != 0);
      recovery_status_i = $urandom;
      case ($urandom % 12)
        0, 1: c = ($urandom % 2) ? 8'd38 : 8'd37;
        2, 3: begin
          c = 8'd47;
          len = $urandom % 80;
        end
        4: c = 8'd45;
        5, 6, 7: rd = 1;
        8: c = ($urandom % 2) ? 8'd46 : 8'd39;
        9: begin
          err = 1;
          rd = $urandom % 2;
        end
        10: begin
          c = 8'd50 + ($urandom % 200);
          rd = $urandom % 2;
        end
        default: begin
          c = 8'd47;
          rd = 1;
        end
      endcase
      run_cmd(rd, c, len, err, rd && ($urandom % 8 == 0));
      // No drains while a FIFO reset may still be clearing
      if (c == 8'd45 && !rd) idle(6, 1'b0);
      idle($urandom % 8 + 1, 1'b1);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display(">>> PASS");
    else $display(">>> FAIL");
    $finish;
  end

  // Each command with its gap stays well under 100 cycles
  initial begin
    #(NumCmds * 100 * 40);
    $display("Timeout: the run did not finish within the command budget");
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: dv/tb_clk_gen.sv
// Testbench clock and reset source, 40 ns period with reset held for the first 5 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    // Released on a falling edge
    #(5 * 40);
    rst_no = 1'b1;
  end

  always #20 clk_o = ~clk_o;

endmodule

// File: src/recovery_executor.sv
// Recovery command executor top level, connecting controller, counter, registers and FIFO
`timescale 1ns/1ps
`include "rec_cfg.svh"

module recovery_executor
  import rec_cmd_pkg::*, rec_csr_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  logic                  cmd_is_rd_i,
  input  rec_cmd_e              cmd_cmd_i,
  input  logic [`REC_LEN_W-1:0] cmd_len_i,
  input  logic                  cmd_error_i,
  output logic                  cmd_done_o,
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output logic [`REC_LEN_W-1:0] res_len_o,
  output logic                  res_dvalid_o,
  input  logic                  res_dready_i,
  output logic [7:0]            res_data_o,
  output logic                  res_dlast_o,
  output logic                  tti_rx_rreq_o,
  input  logic                  tti_rx_rack_i,
  input  rec_word_t             tti_rx_rdata_i,
  input  logic                  fifo_rreq_i,
  output rec_word_t             fifo_rdata_o,
  input  logic                  recovery_mode_enabled_i,
  input  logic                  host_abort_i,
  input  logic [15:0]           recovery_status_i,
  output rec_prot_err_e         prot_error_o,
  output logic [23:0]           device_reset_o,
  output logic [23:0]           recovery_ctrl_o,
  output logic                  rx_queue_clr_o,
  output logic                  payload_available_o,
  output logic                  image_activated_o
);

  localparam int unsigned IdxW = $clog2(`REC_FIFO_DEPTH);

  logic            load, beat, last;
  logic [1:0]      lane;
  rec_csr_idx_e    idx;
  logic            csr_we, fifo_push, fifo_clr, fifo_full, fifo_empty;
  logic [IdxW-1:0] fifo_wr_idx, fifo_rd_idx;

  rec_cmd_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .cmd_valid_i,
    .cmd_is_rd_i,
    .cmd_cmd_i,
    .cmd_len_i,
    .cmd_error_i,
    .recovery_mode_enabled_i,
    .host_abort_i,
    .tti_rx_rack_i,
    .res_ready_i,
    .res_dready_i,
    .last_i        (last),
    .load_o        (load),
    .beat_o        (beat),
    .tti_rx_rreq_o,
    .res_valid_o,
    .res_dvalid_o,
    .res_dlast_o,
    .csr_we_o      (csr_we),
    .fifo_push_o   (fifo_push),
    .cmd_done_o,
    .rx_queue_clr_o,
    .prot_error_o
  );

  rec_xfer_counter u_counter (
    .clk_i,
    .rst_ni,
    .load_i      (load),
    .beat_i      (beat),
    .cmd_is_rd_i,
    .cmd_cmd_i,
    .cmd_len_i,
    .last_o      (last),
    .lane_o      (lane),
    .idx_o       (idx),
    .resp_len_o  (res_len_o)
  );

  rec_csr_file u_csr (
    .clk_i,
    .rst_ni,
    .we_i                (csr_we),
    .idx_i               (idx),
    .lane_i              (lane),
    .wdata_i             (tti_rx_rdata_i),
    .recovery_status_i,
    .fifo_full_i         (fifo_full),
    .fifo_empty_i        (fifo_empty),
    .fifo_wr_idx_i       (fifo_wr_idx),
    .fifo_rd_idx_i       (fifo_rd_idx),
    .res_data_o,
    .device_reset_o,
    .recovery_ctrl_o,
    .image_activated_o,
    .payload_available_o,
    .fifo_clr_o          (fifo_clr)
  );

  rec_indirect_fifo #(
    .Depth (`REC_FIFO_DEPTH)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .push_i   (fifo_push),
    .wdata_i  (tti_rx_rdata_i),
    .pop_i    (fifo_rreq_i),
    .clr_i    (fifo_clr),
    .rdata_o  (fifo_rdata_o),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty),
    .wr_idx_o (fifo_wr_idx),
    .rd_idx_o (fifo_rd_idx)
  );

endmodule

// File: src/rec_indirect_fifo.sv
// Circular indirect image FIFO with wrapping indices, clear, and full and empty flags
`timescale 1ns/1ps
`include "rec_cfg.svh"

module rec_indirect_fifo #(
  parameter int unsigned Depth = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  logic [`REC_DATA_W-1:0]   wdata_i,
  input  logic                     pop_i,
  input  logic                     clr_i,
  output logic [`REC_DATA_W-1:0]   rdata_o,
  output logic                     full_o,
  output logic                     empty_o,
  output logic [$clog2(Depth)-1:0] wr_idx_o,
  output logic [$clog2(Depth)-1:0] rd_idx_o
);

  localparam int unsigned IdxW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [`REC_DATA_W-1:0] mem_q [Depth];
  logic [CntW-1:0]        cnt_q;
  logic                   do_push, do_pop;

  // Overflow and underflow are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_o <= '0;
      rd_idx_o <= '0;
      cnt_q    <= '0;
    end else if (clr_i) begin
      wr_idx_o <= '0;
      rd_idx_o <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_idx_o <= (wr_idx_o == IdxW'(Depth - 1)) ? '0 : wr_idx_o + IdxW'(1);
      if (do_pop) rd_idx_o <= (rd_idx_o == IdxW'(Depth - 1)) ? '0 : rd_idx_o + IdxW'(1);
      if (do_push && !do_pop) cnt_q <= cnt_q + CntW'(1);
      else if (do_pop && !do_push) cnt_q <= cnt_q - CntW'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push && !clr_i) mem_q[wr_idx_o] <= wdata_i;
  end

  assign rdata_o = mem_q[rd_idx_o];
  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);

endmodule

// File: src/rec_csr_file.sv
// Recovery registers with write decode, read word mux, response byte select and status flags
`timescale 1ns/1ps
`include "rec_cfg.svh"

module rec_csr_file
  import rec_csr_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               we_i,
  input  rec_csr_idx_e                       idx_i,
  input  logic [1:0]                         lane_i,
  input  rec_word_t                          wdata_i,
  input  logic [15:0]                        recovery_status_i,
  input  logic                               fifo_full_i,
  input  logic                               fifo_empty_i,
  input  logic [$clog2(`REC_FIFO_DEPTH)-1:0] fifo_wr_idx_i,
  input  logic [$clog2(`REC_FIFO_DEPTH)-1:0] fifo_rd_idx_i,
  output logic [7:0]                         res_data_o,
  output logic [23:0]                        device_reset_o,
  output logic [23:0]                        recovery_ctrl_o,
  output logic                               image_activated_o,
  output logic                               payload_available_o,
  output logic                               fifo_clr_o
);

  logic [7:0] fifo_cms_q;
  logic [7:0] fifo_rst_q;
  rec_word_t  image_size_q;
  rec_word_t  rd_word;
  logic       rst_clr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_reset_o  <= '0;
      recovery_ctrl_o <= '0;
      fifo_cms_q      <= '0;
      fifo_rst_q      <= '0;
      image_size_q    <= '0;
    end else begin
      // Reset byte drops one cycle after the clear unless written again
      if (rst_clr_q) fifo_rst_q <= '0;
      if (we_i) begin
        case (idx_i)
          CSR_DEV_RESET: device_reset_o <= wdata_i[23:0];
          CSR_REC_CTRL:  recovery_ctrl_o <= wdata_i[23:0];
          CSR_FIFO_CTRL_0: begin
            fifo_cms_q <= wdata_i[7:0];
            fifo_rst_q <= wdata_i[15:8];
          end
          CSR_FIFO_CTRL_1: image_size_q <= wdata_i;
          // Status words take no writes
          default: ;
        endcase
      end
    end
  end

  // FIFO clears in the cycle after the reset byte is written
  assign fifo_clr_o = (fifo_rst_q == `REC_FIFO_RESET_CODE);

  // Marks the cycle after the FIFO clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rst_clr_q <= 1'b0;
    else rst_clr_q <= fifo_clr_o;
  end

  always_comb begin
    case (idx_i)
      CSR_DEV_RESET:     rd_word = {8'h00, device_reset_o};
      CSR_REC_CTRL:      rd_word = {8'h00, recovery_ctrl_o};
      CSR_REC_STATUS:    rd_word = {16'h0000, recovery_status_i};
      CSR_FIFO_CTRL_0:   rd_word = {16'h0000, fifo_rst_q, fifo_cms_q};
      CSR_FIFO_CTRL_1:   rd_word = image_size_q;
      CSR_FIFO_STATUS_0: rd_word = {30'd0, fifo_full_i, fifo_empty_i};
      CSR_FIFO_STATUS_1: rd_word = rec_word_t'(fifo_wr_idx_i);
      CSR_FIFO_STATUS_2: rd_word = rec_word_t'(fifo_rd_idx_i);
      CSR_FIFO_STATUS_3: rd_word = rec_word_t'(`REC_FIFO_DEPTH);
      default:           rd_word = '0;
    endcase
  end

  // Little-endian byte order within a word
  assign res_data_o = rd_word[8*lane_i +: 8];

  assign image_activated_o = (recovery_ctrl_o[23:16] == `REC_ACTIVATE_CODE);

  // Set on full or activation and cleared once drained empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      payload_available_o <= 1'b0;
    end else if (!payload_available_o && (fifo_full_i || image_activated_o)) begin
      payload_available_o <= 1'b1;
    end else if (payload_available_o && fifo_empty_i) begin
      payload_available_o <= 1'b0;
    end
  end

endmodule

// File: src/rec_xfer_counter.sv
// Tracks remaining beats, byte lane and register word for the command in flight
`timescale 1ns/1ps
`include "rec_cfg.svh"

module rec_xfer_counter
  import rec_cmd_pkg::*, rec_csr_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  load_i,
  input  logic                  beat_i,
  input  logic                  cmd_is_rd_i,
  input  rec_cmd_e              cmd_cmd_i,
  input  logic [`REC_LEN_W-1:0] cmd_len_i,
  output logic                  last_o,
  output logic [1:0]            lane_o,
  output rec_csr_idx_e          idx_o,
  output logic [`REC_LEN_W-1:0] resp_len_o
);

  localparam int unsigned LenW = `REC_LEN_W;

  logic [LenW-1:0] cnt_q, lookup_len, wr_words, reg_words;
  rec_csr_idx_e    last_idx_q, idx_next;
  logic            is_rd_q;

  assign lookup_len = csr_byte_len(cmd_cmd_i);
  // Bytes to words, rounded up
  assign wr_words   = (cmd_len_i >> 2) + LenW'(|cmd_len_i[1:0]);
  assign reg_words  = (lookup_len + LenW'(3)) >> 2;

  // Stop at NONE past the last register of the command
  assign idx_next = (idx_o == last_idx_q || idx_o == CSR_NONE) ? CSR_NONE
                                                               : rec_csr_idx_e'(idx_o + 4'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      lane_o     <= '0;
      idx_o      <= CSR_NONE;
      last_idx_q <= CSR_NONE;
      is_rd_q    <= 1'b0;
      resp_len_o <= '0;
    end else if (load_i) begin
      cnt_q      <= cmd_is_rd_i ? lookup_len : wr_words;
      lane_o     <= '0;
      idx_o      <= csr_start_idx(cmd_cmd_i);
      last_idx_q <= rec_csr_idx_e'(csr_start_idx(cmd_cmd_i) + reg_words[3:0] - 4'd1);
      is_rd_q    <= cmd_is_rd_i;
      resp_len_o <= lookup_len;
    end else if (beat_i) begin
      cnt_q <= cnt_q - LenW'(1);
      if (is_rd_q) begin
        lane_o <= lane_o + 2'd1;
        if (lane_o == 2'd3) idx_o <= idx_next;
      end else begin
        idx_o <= idx_next;
      end
    end
  end

  assign last_o = (cnt_q == LenW'(1));

endmodule

// File: src/rec_cmd_fsm.sv
// Recovery command controller: checks each command and sequences its write or read phases
`timescale 1ns/1ps
`include "rec_cfg.svh"

module rec_cmd_fsm
  import rec_cmd_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  logic                  cmd_is_rd_i,
  input  rec_cmd_e              cmd_cmd_i,
  input  logic [`REC_LEN_W-1:0] cmd_len_i,
  input  logic                  cmd_error_i,
  input  logic                  recovery_mode_enabled_i,
  input  logic                  host_abort_i,
  input  logic                  tti_rx_rack_i,
  input  logic                  res_ready_i,
  input  logic                  res_dready_i,
  input  logic                  last_i,
  output logic                  load_o,
  output logic                  beat_o,
  output logic                  tti_rx_rreq_o,
  output logic                  res_valid_o,
  output logic                  res_dvalid_o,
  output logic                  res_dlast_o,
  output logic                  csr_we_o,
  output logic                  fifo_push_o,
  output logic                  cmd_done_o,
  output logic                  rx_queue_clr_o,
  output rec_prot_err_e         prot_error_o
);

  rec_state_e    state_q, state_d;
  rec_prot_err_e err_q;
  logic          supported, rec_only, illegal, wr_state, rreq_d;

  always_comb begin
    case (cmd_cmd_i)
      CMD_DEVICE_RESET, CMD_RECOVERY_CTRL, CMD_RECOVERY_STATUS: begin
        supported = 1'b1;
        rec_only  = 1'b0;
      end
      CMD_INDIRECT_FIFO_CTRL, CMD_INDIRECT_FIFO_STATUS, CMD_INDIRECT_FIFO_DATA: begin
        supported = 1'b1;
        rec_only  = 1'b1;
      end
      default: begin
        supported = 1'b0;
        rec_only  = 1'b0;
      end
    endcase
  end

  // FIFO data has no read path
  assign illegal = cmd_error_i || !supported || (rec_only && !recovery_mode_enabled_i)
                || (cmd_is_rd_i && cmd_cmd_i == CMD_INDIRECT_FIFO_DATA);

  assign load_o   = (state_q == Idle) && cmd_valid_i;
  assign wr_state = (state_q == WriteCsr) || (state_q == WriteFifo);
  assign beat_o   = (wr_state && tti_rx_rack_i) || ((state_q == RespData) && res_dready_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (load_o) begin
          if (illegal) state_d = Error;
          else if (cmd_is_rd_i) state_d = RespLen;
          else if (cmd_len_i == '0) state_d = Done;
          else if (cmd_cmd_i == CMD_INDIRECT_FIFO_DATA) state_d = WriteFifo;
          else state_d = WriteCsr;
        end
      end
      WriteCsr, WriteFifo: if (tti_rx_rack_i && last_i) state_d = Done;
      RespLen: if (res_ready_i) state_d = RespData;
      RespData: begin
        if (host_abort_i) state_d = Error;
        else if (beat_o && last_i) state_d = Done;
      end
      Error: state_d = Done;
      default: state_d = Idle;
    endcase
  end

  // One request per word, the next one after each acknowledge
  assign rreq_d = (load_o && !illegal && !cmd_is_rd_i && cmd_len_i != '0)
               || (wr_state && tti_rx_rack_i && !last_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      tti_rx_rreq_o <= 1'b0;
      err_q         <= PROT_OK;
      prot_error_o  <= PROT_OK;
    end else begin
      state_q       <= state_d;
      tti_rx_rreq_o <= rreq_d;
      if (load_o) begin
        err_q <= cmd_error_i ? PROT_CRC : (illegal ? PROT_PARAMETER : PROT_OK);
      end else if (state_q == RespData && host_abort_i) begin
        err_q <= PROT_PARAMETER;
      end
      if (state_q == Done) prot_error_o <= err_q;
    end
  end

  assign res_valid_o    = (state_q == RespLen);
  assign res_dvalid_o   = (state_q == RespData);
  assign res_dlast_o    = (state_q == RespData) && last_i;
  assign csr_we_o       = (state_q == WriteCsr) && tti_rx_rack_i;
  assign fifo_push_o    = (state_q == WriteFifo) && tti_rx_rack_i;
  assign cmd_done_o     = (state_q == Done);
  assign rx_queue_clr_o = (state_q == Error);

endmodule

// File: src/rec_csr_pkg.sv
// Recovery register index and word types, with command to register lookups
package rec_csr_pkg;
  import rec_cmd_pkg::*;
  `include "rec_cfg.svh"

  // Register word index, words of one command are contiguous
  typedef enum logic [3:0] {
    CSR_DEV_RESET     = 4'd0,
    CSR_REC_CTRL      = 4'd1,
    CSR_REC_STATUS    = 4'd2,
    CSR_FIFO_CTRL_0   = 4'd3,
    CSR_FIFO_CTRL_1   = 4'd4,
    CSR_FIFO_STATUS_0 = 4'd5,
    CSR_FIFO_STATUS_1 = 4'd6,
    CSR_FIFO_STATUS_2 = 4'd7,
    CSR_FIFO_STATUS_3 = 4'd8,
    CSR_FIFO_STATUS_4 = 4'd9,
    CSR_NONE          = 4'd15
  } rec_csr_idx_e;

  typedef logic [`REC_DATA_W-1:0] rec_word_t;

  // First register word of a command
  function automatic rec_csr_idx_e csr_start_idx(rec_cmd_e cmd);
    case (cmd)
      CMD_DEVICE_RESET:         return CSR_DEV_RESET;
      CMD_RECOVERY_CTRL:        return CSR_REC_CTRL;
      CMD_RECOVERY_STATUS:      return CSR_REC_STATUS;
      CMD_INDIRECT_FIFO_CTRL:   return CSR_FIFO_CTRL_0;
      CMD_INDIRECT_FIFO_STATUS: return CSR_FIFO_STATUS_0;
      default:                  return CSR_NONE;
    endcase
  endfunction

  // Register length in bytes, zero for FIFO data and unknown codes
  function automatic logic [`REC_LEN_W-1:0] csr_byte_len(rec_cmd_e cmd);
    case (cmd)
      CMD_DEVICE_RESET:         return 3;
      CMD_RECOVERY_CTRL:        return 3;
      CMD_RECOVERY_STATUS:      return 2;
      CMD_INDIRECT_FIFO_CTRL:   return 6;
      CMD_INDIRECT_FIFO_STATUS: return 20;
      default:                  return 0;
    endcase
  endfunction

endpackage

// File: src/rec_cmd_pkg.sv
// Command codes, protocol error codes and controller states shared by the recovery command path
package rec_cmd_pkg;

  // Recovery protocol command codes
  typedef enum logic [7:0] {
    // Always available
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_RECOVERY_STATUS      = 8'd39,
    // Recovery mode only
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } rec_cmd_e;

  // Reported in the protocol error status
  typedef enum logic [7:0] {
    PROT_OK        = 8'h00,
    PROT_PARAMETER = 8'h02,
    PROT_CRC       = 8'h04
  } rec_prot_err_e;

  typedef enum logic [2:0] {
    Idle,
    WriteCsr,
    WriteFifo,
    RespLen,
    RespData,
    Error,
    Done
  } rec_state_e;

endpackage

// File: src/rec_cfg.svh
// Widths, FIFO depth and protocol byte codes, included by the recovery RTL and its packages
`ifndef REC_CFG_SVH
`define REC_CFG_SVH

// Receive queue and FIFO word width
`define REC_DATA_W 32

// Command length field width
`define REC_LEN_W 16

// Indirect image FIFO depth in words
`define REC_FIFO_DEPTH 16

// RECOVERY_CTRL activate byte for an activated image
`define REC_ACTIVATE_CODE 8'h0F

// INDIRECT_FIFO_CTRL reset byte that empties the FIFO
`define REC_FIFO_RESET_CODE 8'h01

`endif
